/* common/alut_pkg.sv */
package alut_pkg;

   // ----------------------------------------
   // table geometry and time
   // ----------------------------------------
   localparam int ALUT_DEPTH = 256;   // entries in the lookup table
   localparam int ALUT_AW    = 8;     // hash width == table address width
   localparam int TIME_W     = 32;    // time stamps and age limit

   // destination port masks, bit 4 is the switch itself
   localparam logic [4:0] PORT_MAC   = 5'b1_0000;
   localparam logic [4:0] PORT_FLOOD = 5'b0_1111;   // every ethernet port

   // ----------------------------------------
   // commands and table words
   // ----------------------------------------
   typedef enum logic [1:0]
   {
      cmd_none  = 2'b00,   // nothing to do
      cmd_check = 2'b01    // check destination, learn source
   } alut_cmd_t;

   // one table word, valid on top
   typedef struct packed {
      logic              valid;       // entry has been learned
      logic [TIME_W-1:0] last_time;   // curr_time when written
      logic [1:0]        port;        // port the address came in on
      logic [47:0]       addr;        // learned source address
   } alut_entry_t;

   // frame under check, held by the source while active
   typedef struct packed {
      logic [47:0] d_addr;   // destination address
      logic [47:0] s_addr;   // source address, learned
      logic [1:0]  s_port;   // port the frame arrived on
   } alut_frame_t;

   // entry lost when a different source overwrote it
   typedef struct packed {
      logic [47:0] addr;
      logic [1:0]  port;
   } alut_inv_t;

   // address checker states
   typedef enum logic [2:0]
   {
      idle         = 3'd0,
      mac_addr_chk = 3'd1,   // destination against own mac
      read_dest    = 3'd2,   // table read at destination hash
      valid_chk    = 3'd3,
      age_chk      = 3'd4,   // request, wait, confirm
      addr_chk     = 3'd5,   // final compare, d_port set here
      read_src     = 3'd6,   // old entry at source hash
      write_src    = 3'd7
   } add_chk_state_t;

endpackage

/* alut/alut_mem.sv */
`timescale 1ns/100ps

module alut_mem (
   input  logic                         pclk2,
   input  logic                         n_p_reset2,
   input  logic [alut_pkg::ALUT_AW-1:0] mem_addr,    // registered by the checker
   input  logic                         mem_write,
   input  alut_pkg::alut_entry_t        mem_wdata,
   output alut_pkg::alut_entry_t        mem_rdata
);
   import alut_pkg::*;

   alut_entry_t           words [ALUT_DEPTH];   // address, port and stamp
   logic [ALUT_DEPTH-1:0] valid_q;              // one bit per entry, cleared on reset

   // ----------------------------------------
   // write side
   // ----------------------------------------
   always_ff @(posedge pclk2)
   begin
      if (mem_write)
         words[mem_addr] <= mem_wdata;
   end

   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         valid_q <= '0;   // empty table
      else if (mem_write)
         valid_q[mem_addr] <= mem_wdata.valid;
   end

   // read in the same cycle, valid from the vector wins
   always_comb
   begin
      mem_rdata       = words[mem_addr];
      mem_rdata.valid = valid_q[mem_addr];
   end

endmodule

/* alut/alut_age_checker.sv */
`timescale 1ns/100ps

module alut_age_checker (
   input  logic                        pclk2,
   input  logic                        n_p_reset2,
   input  logic                        check_age,       // request strobe
   input  logic [alut_pkg::TIME_W-1:0] last_accessed,   // stamp of the entry
   input  logic [alut_pkg::TIME_W-1:0] max_age,         // oldest still in date
   output logic [alut_pkg::TIME_W-1:0] curr_time,
   output logic                        age_confirmed,
   output logic                        age_ok
);
   import alut_pkg::*;

   logic [TIME_W-1:0] entry_age;

   // wraps mod 2^32 so a counter rollover still gives the right age
   assign entry_age = curr_time - last_accessed;

   // ----------------------------------------
   // free running time base
   // ----------------------------------------
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;   // one tick per clock
   end

   // answer each request one cycle later
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (entry_age < max_age);   // held until next request
      end
   end

   // each answer follows a request that lasted a single cycle
   a_confirm_follows_req: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      age_confirmed |-> $past(check_age) && !check_age);

endmodule

/* alut/alut_addr_checker.sv */
`timescale 1ns/100ps

module alut_addr_checker (
   input  logic                         pclk2,
   input  logic                         n_p_reset2,
   input  alut_pkg::alut_cmd_t          command,         // software strobe
   input  logic [47:0]                  mac_addr,        // switch's own address
   input  alut_pkg::alut_frame_t        frame,
   input  logic [alut_pkg::TIME_W-1:0]  curr_time,       // stamped into new entries
   input  alut_pkg::alut_entry_t        mem_rdata,
   input  logic                         age_confirmed,   // age answer strobe
   input  logic                         age_ok,          // entry still in date
   input  logic                         clear_reused,
   output logic [4:0]                   d_port,
   output logic                         add_check_active,
   output logic [alut_pkg::ALUT_AW-1:0] mem_addr,
   output logic                         mem_write,
   output alut_pkg::alut_entry_t        mem_wdata,
   output logic                         check_age,
   output logic [alut_pkg::TIME_W-1:0]  last_accessed,
   output logic                         reused,
   output alut_pkg::alut_inv_t          lst_inv
);
   import alut_pkg::*;

   add_chk_state_t     add_chk_state;
   add_chk_state_t     nxt_add_chk_state;
   logic [ALUT_AW-1:0] s_hash;        // where the source gets learned
   logic [ALUT_AW-1:0] d_hash;        // where the destination is looked up
   logic               mac_hit;       // frame addressed to the switch
   logic               dest_hit;      // survives valid and age checks
   logic [4:0]         stored_mask;   // one-hot of port read from table
   logic [4:0]         src_mask;      // never send back where it came from

   // xor of the six address bytes
   function automatic logic [ALUT_AW-1:0] addr_hash(input logic [47:0] addr);
      logic [ALUT_AW-1:0] h;
      h = '0;
      for (int i = 0; i < 6; i++)
      begin
         h = h ^ addr[i*8 +: 8];
      end
      return h;
   endfunction

   assign s_hash      = addr_hash(frame.s_addr);
   assign d_hash      = addr_hash(frame.d_addr);
   assign mac_hit     = (frame.d_addr == mac_addr);
   assign stored_mask = {1'b0, 4'b0001 << mem_rdata.port};
   assign src_mask    = 5'b0_0001 << frame.s_port;

   // ----------------------------------------
   // check / learn FSM
   // ----------------------------------------
   always_comb
   begin
      nxt_add_chk_state = add_chk_state;
      case (add_chk_state)
         idle:
            if (command == cmd_check)
               nxt_add_chk_state = mac_addr_chk;   // other commands dropped
         mac_addr_chk:
            nxt_add_chk_state = mac_hit ? idle : read_dest;
         read_dest:    nxt_add_chk_state = valid_chk;
         valid_chk:    nxt_add_chk_state = age_chk;
         age_chk:
            if (age_confirmed)
               nxt_add_chk_state = addr_chk;   // answer is back on the third cycle
         addr_chk:     nxt_add_chk_state = read_src;
         read_src:     nxt_add_chk_state = write_src;
         write_src:    nxt_add_chk_state = idle;
         default:      nxt_add_chk_state = idle;
      endcase
   end

   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         add_chk_state <= idle;
      else
         add_chk_state <= nxt_add_chk_state;
   end

   assign add_check_active = (add_chk_state != idle);

   // ----------------------------------------
   // destination lookup result
   // ----------------------------------------
   // hit starts from the valid bit and is knocked out by a stale age
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         dest_hit <= 1'b0;
      else if (add_chk_state == valid_chk)
         dest_hit <= mem_rdata.valid;
      else if (add_chk_state == age_chk && age_confirmed)
         dest_hit <= dest_hit & age_ok;
   end

   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         d_port <= PORT_FLOOD;
      else if (add_chk_state == mac_addr_chk && mac_hit)
         d_port <= PORT_MAC;
      else if (add_chk_state == addr_chk)
      begin
         // table still at destination hash here
         if (dest_hit && mem_rdata.addr == frame.d_addr)
            d_port <= stored_mask & ~src_mask;
         else
            d_port <= PORT_FLOOD & ~src_mask;   // unknown so flood the others
      end
   end

   // ----------------------------------------
   // table address and write strobe
   // ----------------------------------------
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         mem_addr  <= '0;
         mem_write <= 1'b0;
      end
      else
      begin
         // source hash presented from read_src on and destination hash before
         if (add_chk_state == addr_chk || add_chk_state == read_src ||
             add_chk_state == write_src)
            mem_addr <= s_hash;
         else
            mem_addr <= d_hash;
         mem_write <= (add_chk_state == write_src);   // lands one cycle later
      end
   end

   // learned entries are always valid
   assign mem_wdata = '{valid: 1'b1, last_time: curr_time,
                        port: frame.s_port, addr: frame.s_addr};

   // ----------------------------------------
   // overwrite tracking
   // ----------------------------------------
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         reused  <= 1'b0;
         lst_inv <= '0;
      end
      else if (add_chk_state == read_src && mem_rdata.valid &&
               mem_rdata.addr != frame.s_addr)
      begin
         reused  <= 1'b1;                                     // someone else's slot
         lst_inv <= '{addr: mem_rdata.addr, port: mem_rdata.port};
      end
      else if (clear_reused)
         reused <= 1'b0;   // lst_inv kept for software
   end

   // ----------------------------------------
   // age request
   // ----------------------------------------
   // one pulse on the first age_chk cycle only
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         check_age <= 1'b0;
      else
         check_age <= (add_chk_state == age_chk) && !check_age && !age_confirmed;
   end

   always_ff @(posedge pclk2)
   begin
      if (add_chk_state == age_chk && !check_age && !age_confirmed)
         last_accessed <= mem_rdata.last_time;   // destination entry stamp
   end

   // mac mask and ethernet ports are exclusive
   a_dport_excl: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      !(d_port[4] && |d_port[3:0]));

   // the write strobe only follows write_src and lands on the source hash
   a_write_after_src: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      mem_write |-> ($past(add_chk_state) == write_src) && (mem_addr == s_hash));

endmodule

/* hdl/alut_top.sv */
`timescale 1ns/100ps

module alut_top (
   input  logic                        pclk2,
   input  logic                        n_p_reset2,
   input  alut_pkg::alut_cmd_t         command,
   input  logic [47:0]                 mac_addr,
   input  alut_pkg::alut_frame_t       frame,
   input  logic [alut_pkg::TIME_W-1:0] max_age,
   input  logic                        clear_reused,
   output logic [4:0]                  d_port,
   output logic                        add_check_active,
   output logic                        reused,
   output alut_pkg::alut_inv_t         lst_inv
);
   import alut_pkg::*;

   // checker to table
   logic [ALUT_AW-1:0] mem_addr;
   logic               mem_write;
   alut_entry_t        mem_wdata;
   alut_entry_t        mem_rdata;

   // checker to age checker and back
   logic               check_age;
   logic [TIME_W-1:0]  last_accessed;
   logic [TIME_W-1:0]  curr_time;
   logic               age_confirmed;
   logic               age_ok;

   alut_addr_checker i_alut_addr_checker (
      .pclk2            (pclk2),
      .n_p_reset2       (n_p_reset2),
      .command          (command),
      .mac_addr         (mac_addr),
      .frame            (frame),
      .curr_time        (curr_time),
      .mem_rdata        (mem_rdata),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .mem_addr         (mem_addr),
      .mem_write        (mem_write),
      .mem_wdata        (mem_wdata),
      .check_age        (check_age),
      .last_accessed    (last_accessed),
      .reused           (reused),
      .lst_inv          (lst_inv)
   );

   alut_age_checker i_alut_age_checker (
      .pclk2         (pclk2),
      .n_p_reset2    (n_p_reset2),
      .check_age     (check_age),
      .last_accessed (last_accessed),
      .max_age       (max_age),
      .curr_time     (curr_time),
      .age_confirmed (age_confirmed),
      .age_ok        (age_ok)
   );

   alut_mem i_alut_mem (
      .pclk2      (pclk2),
      .n_p_reset2 (n_p_reset2),
      .mem_addr   (mem_addr),
      .mem_write  (mem_write),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata)
   );

endmodule

/* test/tb_alut.sv */
`timescale 1ns/100ps

module tb_alut;
   import alut_pkg::*;

   localparam int WATCHDOG_CYCLES = 300 * 20;   // frames times cycles per frame

   // DUT inputs
   logic        pclk2;
   logic        n_p_reset2;
   alut_cmd_t   command;
   logic [47:0] mac_addr;
   alut_frame_t frame;
   logic [TIME_W-1:0] max_age;
   logic        clear_reused;
   // DUT outputs
   logic [4:0]  d_port;
   logic        add_check_active;
   logic        reused;
   alut_inv_t   lst_inv;

   // reference table and expected state
   alut_entry_t       model_tab [ALUT_DEPTH];
   logic [TIME_W-1:0] model_max_age;
   logic [4:0]        exp_port;
   logic              exp_reused;
   alut_inv_t         exp_inv;
   // sampled outputs for the compare process
   logic [4:0]        act_port;
   logic              act_reused;
   alut_inv_t         act_inv;
   event              sampled;

   int unsigned cycle_cnt;   // testbench time base in clocks
   int          pass_cnt;
   int          fail_cnt;
   int          test_mark;
   string       test_name;
   integer      seed;
   logic [47:0] pool [8];    // small pool so hashes collide

   alut_top i_alut_top (
      .pclk2            (pclk2),
      .n_p_reset2       (n_p_reset2),
      .command          (command),
      .mac_addr         (mac_addr),
      .frame            (frame),
      .max_age          (max_age),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .reused           (reused),
      .lst_inv          (lst_inv)
   );

   initial
   begin
      pclk2 = 1'b0;
      forever #5 pclk2 = ~pclk2;   // 10 ns period
   end

   always @(posedge pclk2)
      cycle_cnt <= cycle_cnt + 1;

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   // xor of all six bytes
   function automatic logic [7:0] byte_xor(input logic [47:0] a);
      return a[47:40] ^ a[39:32] ^ a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
   endfunction

   // lookup then learn into the table and the expected outputs
   function automatic void ref_lookup(input alut_frame_t f, input logic [47:0] own,
                                      input int unsigned now);
      alut_entry_t d_ent;
      alut_entry_t s_ent;
      logic [4:0]  src_bit;
      src_bit = 5'b0_0001 << f.s_port;
      if (f.d_addr == own)
      begin
         exp_port = PORT_MAC;   // nothing learned
         return;
      end
      d_ent = model_tab[byte_xor(f.d_addr)];
      if (d_ent.valid && (now - d_ent.last_time) < model_max_age && d_ent.addr == f.d_addr)
         exp_port = (5'b0_0001 << d_ent.port) & ~src_bit;
      else
         exp_port = PORT_FLOOD & ~src_bit;
      s_ent = model_tab[byte_xor(f.s_addr)];
      if (s_ent.valid && s_ent.addr != f.s_addr)
      begin
         exp_reused = 1'b1;   // sticky until cleared
         exp_inv    = '{addr: s_ent.addr, port: s_ent.port};
      end
      model_tab[byte_xor(f.s_addr)] = '{valid: 1'b1, last_time: now,
                                        port: f.s_port, addr: f.s_addr};
   endfunction

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_port(input string name, input logic [4:0] exp, input logic [4:0] act);
      if (exp !== act)
      begin
         $display("[ERROR] %s d_port expected %b actual %b", name, exp, act);
         fail_cnt++;
      end
      else
         pass_cnt++;
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("[ERROR] %s reused expected %b actual %b", name, exp, act);
         fail_cnt++;
      end
      else
         pass_cnt++;
   endtask

   task automatic check_inv(input string name, input alut_inv_t exp, input alut_inv_t act);
      if (exp !== act)
      begin
         $display("[ERROR] %s lst_inv expected %h/%0d actual %h/%0d",
                  name, exp.addr, exp.port, act.addr, act.port);
         fail_cnt++;
      end
      else
         pass_cnt++;
   endtask

   task automatic check_busy(input string name, input int exp, input int act);
      if (exp != act)
      begin
         $display("[ERROR] %s add_check_active cycles expected %0d actual %0d",
                  name, exp, act);
         fail_cnt++;
      end
      else
         pass_cnt++;
   endtask

   always @(sampled)
   begin
      check_port(test_name, exp_port, act_port);
      check_flag(test_name, exp_reused, act_reused);
      check_inv(test_name, exp_inv, act_inv);
   end

   // ----------------------------------------
   // stimulus tasks entered 1 ns after an edge
   // ----------------------------------------
   task automatic sample_and_compare();
      act_port   = d_port;
      act_reused = reused;
      act_inv    = lst_inv;
      -> sampled;
      @(posedge pclk2);   // compare runs and the learned word is written
      #1;
   endtask

   task automatic send_frame(input logic [47:0] dst, input logic [47:0] src,
                             input logic [1:0] port);
      int n;
      int exp_busy;
      exp_busy = (dst == mac_addr) ? 1 : 9;   // switch frames stop after the mac compare
      frame    = '{d_addr: dst, s_addr: src, s_port: port};
      command  = cmd_check;
      ref_lookup(frame, mac_addr, cycle_cnt);
      @(posedge pclk2);
      #1;
      command = cmd_none;   // one cycle strobe
      n = 0;
      while (!add_check_active && n < 4)
      begin
         @(posedge pclk2);
         #1;
         n++;
      end
      if (!add_check_active)
      begin
         $display("%s: add_check_active never rose after the check command", test_name);
         fail_cnt++;
      end
      n = 0;
      while (add_check_active && n < 20)
      begin
         @(posedge pclk2);
         #1;
         n++;
      end
      if (add_check_active)
      begin
         $display("%s: add_check_active stayed high, the check did not finish", test_name);
         fail_cnt++;
      end
      check_busy(test_name, exp_busy, n);
      sample_and_compare();
   endtask

   task automatic pulse_clear_reused();
      clear_reused = 1'b1;
      @(posedge pclk2);
      #1;
      clear_reused = 1'b0;
      exp_reused   = 1'b0;   // lst_inv stays
      sample_and_compare();
   endtask

   task automatic set_age_limit(input logic [TIME_W-1:0] v);
      max_age       = v;
      model_max_age = v;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge pclk2);
      #1;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_mark = fail_cnt;
   endtask

   task automatic end_test();
      if (fail_cnt == test_mark)
         $display("test %s: ok", test_name);
      else
         $display("test %s: %0d errors", test_name, fail_cnt - test_mark);
   endtask

   // ----------------------------------------
   // watchdog
   // ----------------------------------------
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge pclk2);
      $display("watchdog expired after %0d cycles, the DUT appears to hang", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial
   begin
      n_p_reset2   = 1'b0;
      command      = cmd_none;
      mac_addr     = 48'h00_0a_0b_0c_0d_0e;   // switch's own address
      frame        = '0;
      clear_reused = 1'b0;
      cycle_cnt    = 0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      seed         = 32'heaf6_a415;
      exp_port     = PORT_FLOOD;
      exp_reused   = 1'b0;
      exp_inv      = '0;
      set_age_limit(1_000_000);
      for (int i = 0; i < ALUT_DEPTH; i++)
         model_tab[i] = '0;
      pool[0] = 48'h02_00_00_00_00_11;   // same hash as pool[1]
      pool[1] = 48'h02_00_00_00_11_00;
      pool[2] = 48'h02_00_00_00_00_22;   // same hash as pool[3]
      pool[3] = 48'h02_00_00_00_22_00;
      pool[4] = 48'h02_00_00_00_00_33;
      pool[5] = 48'h02_00_00_00_00_44;
      pool[6] = 48'h02_00_00_00_00_77;
      pool[7] = mac_addr;                // some frames go to the switch

      repeat (4) @(posedge pclk2);
      #1;
      n_p_reset2 = 1'b1;

      begin_test("reset");
      sample_and_compare();
      end_test();

      begin_test("mac_hit");
      send_frame(48'h06_00_00_00_00_08, 48'h04_00_00_00_01_00, 2'd1);   // fills hash 05
      send_frame(mac_addr, 48'h04_00_00_00_00_01, 2'd3);   // learning here would set reused
      send_frame(48'h04_00_00_00_00_01, 48'h04_00_00_00_00_02, 2'd0);   // not learned
      end_test();

      begin_test("unknown");
      send_frame(48'h06_00_00_00_00_09, 48'h04_00_00_00_00_03, 2'd1);
      end_test();

      begin_test("learned");
      send_frame(48'h06_00_00_00_00_0a, 48'h08_00_00_00_00_01, 2'd2);
      send_frame(48'h08_00_00_00_00_01, 48'h08_00_00_00_00_02, 2'd0);
      send_frame(48'h08_00_00_00_00_01, 48'h08_00_00_00_00_03, 2'd2);   // same port so no route
      end_test();

      begin_test("aging");
      send_frame(48'h06_00_00_00_00_0b, 48'h0a_00_00_00_00_01, 2'd1);
      set_age_limit(20);
      wait_cycles(200);
      send_frame(48'h0a_00_00_00_00_01, 48'h0a_00_00_00_00_02, 2'd3);   // stale so it floods
      set_age_limit(1_000_000);
      send_frame(48'h06_00_00_00_00_0b, 48'h0a_00_00_00_00_01, 2'd1);
      wait_cycles(200);
      send_frame(48'h0a_00_00_00_00_01, 48'h0a_00_00_00_00_03, 2'd0);   // still in date
      end_test();

      begin_test("reused");
      pulse_clear_reused();
      send_frame(48'h0e_0e_0e_0e_0e_0e, 48'h02_00_00_00_00_55, 2'd1);
      send_frame(48'h0e_0e_0e_0e_0e_0e, 48'h02_00_00_00_55_00, 2'd2);   // equal hash
      pulse_clear_reused();
      end_test();

      begin_test("random");
      for (int i = 0; i < 200; i++)
         send_frame(pool[$random(seed) & 7], pool[$random(seed) & 7], 2'($random(seed)));
      end_test();

      $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* build.f */
common/alut_pkg.sv
alut/alut_mem.sv
alut/alut_age_checker.sv
alut/alut_addr_checker.sv
hdl/alut_top.sv
test/tb_alut.sv

/* Makefile */
# Verilator build and run for the ALUT testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_alut
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
